//--- source/router_pkg.sv
package router_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int CMD_W   = 32;     // host command word
   localparam int COORD_W = 5;      // one x, y or z field in a command

   // command opcode in bits 31:30
   typedef enum logic [1:0] {
      OP_NOP      = 2'd0,
      OP_ROUTE    = 2'd1,           // not handled here, consumed as a nop
      OP_SELECT   = 2'd2,
      OP_EXTENDED = 2'd3
   } opcode_e;

   // extended function in bits 29:26
   typedef enum logic [3:0] {
      FCN_WRITE        = 4'd0,
      FCN_READ         = 4'd1,
      FCN_CLEAR_ARRAY  = 4'd2,
      FCN_CLEARX       = 4'd3,
      FCN_ROUTE_EXTEND = 4'd4       // consumed as a nop
   } ext_fcn_e;

   // command to the cells, read with decoders off is the idle case
   typedef enum logic [1:0] {
      CELL_READ   = 2'd0,
      CELL_WRITE  = 2'd1,
      CELL_EXPAND = 2'd2,
      CELL_CLEARX = 2'd3
   } cell_cmd_e;

   // range decoder select, one for rows and one for columns
   typedef enum logic [2:0] {
      DEC_DISABLE = 3'd0,
      DEC_LOWER   = 3'd1,           // only the p1 coordinate
      DEC_UPPER   = 3'd2,           // only the p2 coordinate
      DEC_RANGE   = 3'd3,           // p1 up to p2
      DEC_ALL     = 3'd4
   } decode_sel_e;

   // cell status, bit 3 low means unetched
   typedef enum logic [3:0] {
      ST_EMPTY_CELL = 4'h0,
      ST_XE         = 4'h3,
      ST_TRACED     = 4'h7
   } cell_status_e;

   // result code in bits 31:29 of a result word
   typedef enum logic [2:0] {
      RES_ETCH    = 3'd0,
      RES_SUCCESS = 3'd1,
      RES_XFAIL   = 3'd2,
      RES_TFAIL   = 3'd3,
      RES_TRACE   = 3'd4,
      RES_XCOUNT  = 3'd5,
      RES_TCOUNT  = 3'd6,
      RES_STATUS  = 3'd7
   } result_code_e;

   // controller states
   typedef enum logic [4:0] {
      S_WAIT         = 5'd0,
      S_LOAD         = 5'd1,
      S_DECODE       = 5'd2,
      S_SELECT       = 5'd3,
      S_WRITE        = 5'd4,
      S_WRITE_REST   = 5'd5,
      S_READ         = 5'd6,
      S_READ_OUT     = 5'd7,
      S_CLEARX       = 5'd8,
      S_CLEAR_ALL    = 5'd9,
      S_CLEAR_ALL_WR = 5'd10
   } ctl_state_e;

   // --------------------------------------------------
   // structs
   // --------------------------------------------------
   typedef struct packed {
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
      logic [COORD_W-1:0] z;
   } point_t;

   typedef struct packed {
      opcode_e     opcode;
      ext_fcn_e    fcn;
      logic [3:0]  status;          // status to write, low bits of the word
      point_t      p1;
      point_t      p2;
   } cmd_fields_t;

   typedef struct packed {
      decode_sel_e        row_sel;
      decode_sel_e        col_sel;
      logic [COORD_W-1:0] row_l;    // y1
      logic [COORD_W-1:0] row_u;    // y2
      logic [COORD_W-1:0] col_l;    // x1
      logic [COORD_W-1:0] col_u;    // x2
      cell_cmd_e          cell_cmd;
      logic [3:0]         status_wr;
   } array_ctl_t;

endpackage

//--- source/cmd_fetch.sv
module cmd_fetch
   import router_pkg::*;
(
   input  logic             clk,
   input  logic             fourlayer_cnt_reset,
   input  logic [CMD_W-1:0] cmd_in,       // fifo word, valid the cycle after cmd_rd
   input  logic             cmdreg_lden,
   output cmd_fields_t      fields
);

   logic [CMD_W-1:0] cmd_reg;

   // command register, clears to a nop word
   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
         cmd_reg <= '0;
      else if (cmdreg_lden)
         cmd_reg <= cmd_in;
   end

   // --------------------------------------------------
   // field split
   // --------------------------------------------------
   assign fields.opcode = opcode_e'(cmd_reg[31:30]);
   assign fields.fcn    = ext_fcn_e'(cmd_reg[29:26]);   // overlaps x1 of a select
   assign fields.status = cmd_reg[3:0];                 // overlaps z2

   // select layout, six 5-bit groups from bit 29 down
   assign fields.p1.x   = cmd_reg[29:25];
   assign fields.p1.y   = cmd_reg[24:20];
   assign fields.p1.z   = cmd_reg[19:15];
   assign fields.p2.x   = cmd_reg[14:10];
   assign fields.p2.y   = cmd_reg[9:5];
   assign fields.p2.z   = cmd_reg[4:0];

endmodule

//--- source/endpoint_regs.sv
module endpoint_regs
   import router_pkg::*;
#(
   parameter int NLBITS = 2,
   parameter int NRBITS = 4,
   parameter int NCBITS = 4
)
(
   input  logic              clk,
   input  logic              fourlayer_cnt_reset,
   input  logic              sel_lden,
   input  cmd_fields_t       fields,
   input  logic [NLBITS-1:0] cur_layer,
   output point_t            p1,
   output point_t            p2,
   output logic              layer_start,   // on the p1 layer
   output logic              layer_last     // on the p2 layer
);

   // held at array size, upper command bits dropped
   logic [NCBITS-1:0] x1, x2;
   logic [NRBITS-1:0] y1, y2;
   logic [NLBITS-1:0] z1, z2;

   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         x1 <= '0;
         y1 <= '0;
         z1 <= '0;
         x2 <= '0;
         y2 <= '0;
         z2 <= '0;
      end
      else if (sel_lden)
      begin
         x1 <= fields.p1.x[NCBITS-1:0];
         y1 <= fields.p1.y[NRBITS-1:0];
         z1 <= fields.p1.z[NLBITS-1:0];
         x2 <= fields.p2.x[NCBITS-1:0];
         y2 <= fields.p2.y[NRBITS-1:0];
         z2 <= fields.p2.z[NLBITS-1:0];
      end
   end

   // zero padded back to the command field width
   assign p1 = '{x: COORD_W'(x1), y: COORD_W'(y1), z: COORD_W'(z1)};
   assign p2 = '{x: COORD_W'(x2), y: COORD_W'(y2), z: COORD_W'(z2)};

   // layer match as the counter rotates
   assign layer_start = (cur_layer == z1);
   assign layer_last  = (cur_layer == z2);

endmodule

//--- source/layer_counter.sv
module layer_counter #(
   parameter int NLAYERS = 4,
   parameter int NLBITS  = 2
)
(
   input  logic              clk,
   input  logic              fourlayer_cnt_reset,
   input  logic              advance,
   output logic [NLBITS-1:0] cur_layer,
   output logic              top_l            // low on the top layer
);

   localparam logic [NLBITS-1:0] TOP = NLBITS'(NLAYERS - 1);

   // modulo NLAYERS, so the count also works for a non power of two
   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
         cur_layer <= '0;
      else if (advance)
         cur_layer <= (cur_layer == TOP) ? '0 : cur_layer + 1'b1;
   end

   // the next advance from here wraps to layer 0
   assign top_l = (cur_layer != TOP);

endmodule

//--- source/route_ctl_fsm.sv
module route_ctl_fsm
   import router_pkg::*;
#(
   parameter int NLAYERS = 4,
   parameter int NLBITS  = 2
)
(
   input  logic        clk,
   input  logic        fourlayer_cnt_reset,
   input  logic        cmd_empty,
   input  logic        result_full,
   input  cmd_fields_t fields,
   input  logic        layer_start,
   input  logic        layer_last,
   input  logic        top_l,
   output logic        cmd_rd,        // fifo pop, one cycle
   output logic        cmdreg_lden,
   output logic        sel_lden,
   output logic        advance,       // step the layer counter
   output decode_sel_e row_sel,
   output decode_sel_e col_sel,
   output cell_cmd_e   cell_cmd,
   output logic        status_src,    // 0 command status, 1 empty cell
   output logic        result_wr
);

   ctl_state_e        cs, ns;
   logic [NLBITS-1:0] pass_cnt;   // layers left in a clearx pass
   logic              pass_load;
   logic              skip;       // command consumed without action

   // --------------------------------------------------
   // state and pass counter
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         cs       <= S_WAIT;
         pass_cnt <= '0;
      end
      else
      begin
         cs <= ns;
         if (pass_load)
            pass_cnt <= NLBITS'(NLAYERS - 1);
         else if (cs == S_CLEARX && pass_cnt != '0)
            pass_cnt <= pass_cnt - 1'b1;
      end
   end

   // --------------------------------------------------
   // next state and strobes
   // --------------------------------------------------
   always_comb
   begin
      ns          = S_WAIT;
      cmd_rd      = 1'b0;
      cmdreg_lden = 1'b0;
      sel_lden    = 1'b0;
      advance     = 1'b0;
      row_sel     = DEC_DISABLE;
      col_sel     = DEC_DISABLE;
      cell_cmd    = CELL_READ;      // read with decoders off does nothing
      status_src  = 1'b0;
      result_wr   = 1'b0;
      pass_load   = 1'b0;
      skip        = 1'b0;

      case (cs)
         S_WAIT:
         begin
            if (!cmd_empty)
            begin
               cmd_rd = 1'b1;       // word shows up after this edge
               ns     = S_LOAD;
            end
         end
         S_LOAD:
         begin
            cmdreg_lden = 1'b1;
            ns          = S_DECODE;
         end
         S_DECODE:
         begin
            case (fields.opcode)
               OP_SELECT: ns = S_SELECT;
               OP_EXTENDED:
               begin
                  case (fields.fcn)
                     FCN_WRITE:
                     begin
                        row_sel = DEC_RANGE;   // decoders primed a cycle early
                        col_sel = DEC_RANGE;
                        ns      = S_WRITE;
                     end
                     FCN_READ:
                     begin
                        row_sel = DEC_LOWER;
                        col_sel = DEC_LOWER;
                        ns      = S_READ;
                     end
                     FCN_CLEAR_ARRAY: ns = S_CLEAR_ALL;
                     FCN_CLEARX:
                     begin
                        pass_load = 1'b1;
                        ns        = S_CLEARX;
                     end
                     default: skip = 1'b1;    // route extend and unknown
                  endcase
               end
               default: skip = 1'b1;          // nop and route
            endcase
            // chain into the next word without passing through wait
            if (skip && !cmd_empty)
            begin
               cmd_rd = 1'b1;
               ns     = S_LOAD;
            end
         end
         S_SELECT:
         begin
            sel_lden = 1'b1;        // p1 and p2 out after the next edge
            ns       = S_WAIT;
         end
         S_WRITE:
         begin
            advance = 1'b1;
            row_sel = DEC_RANGE;
            col_sel = DEC_RANGE;
            ns      = S_WRITE;      // spin until z1 comes round
            if (layer_start)
            begin
               cell_cmd = CELL_WRITE;
               ns       = layer_last ? S_WAIT : S_WRITE_REST;
            end
         end
         S_WRITE_REST:
         begin
            advance  = 1'b1;        // remaining layers up to z2
            row_sel  = DEC_RANGE;
            col_sel  = DEC_RANGE;
            cell_cmd = CELL_WRITE;
            ns       = layer_last ? S_WAIT : S_WRITE_REST;
         end
         S_READ:
         begin
            row_sel = DEC_LOWER;
            col_sel = DEC_LOWER;
            ns      = S_READ;
            if (!layer_start)
               advance = 1'b1;
            else if (!result_full)
               ns = S_READ_OUT;     // layer held, status stays valid
         end
         S_READ_OUT:
         begin
            row_sel = DEC_LOWER;
            col_sel = DEC_LOWER;
            ns      = S_READ_OUT;
            if (!result_full)
            begin
               result_wr = 1'b1;
               ns        = S_WAIT;
            end
         end
         S_CLEARX:
         begin
            advance  = 1'b1;
            cell_cmd = CELL_CLEARX;
            ns       = (pass_cnt == '0) ? S_WAIT : S_CLEARX;
         end
         S_CLEAR_ALL:
         begin
            advance = 1'b1;         // run up to the top layer first
            row_sel = DEC_ALL;
            col_sel = DEC_ALL;
            ns      = top_l ? S_CLEAR_ALL : S_CLEAR_ALL_WR;
         end
         S_CLEAR_ALL_WR:
         begin
            advance    = 1'b1;      // starts on layer 0
            row_sel    = DEC_ALL;
            col_sel    = DEC_ALL;
            cell_cmd   = CELL_WRITE;
            status_src = 1'b1;
            ns         = top_l ? S_CLEAR_ALL_WR : S_WAIT;
         end
         default: ns = S_WAIT;
      endcase
   end

endmodule

//--- source/array_port.sv
module array_port
   import router_pkg::*;
(
   input  point_t           p1,
   input  point_t           p2,
   input  cmd_fields_t      fields,
   input  decode_sel_e      row_sel,
   input  decode_sel_e      col_sel,
   input  cell_cmd_e        cell_cmd,
   input  logic             status_src,
   input  logic             result_wr_en,
   input  logic [3:0]       status_rd,    // cell at p1 on the current layer
   output array_ctl_t       array_ctl,
   output logic [CMD_W-1:0] result_out,
   output logic             result_wr
);

   logic [3:0] status_wr;

   // write value, command status or the empty code for a full clear
   assign status_wr = status_src ? 4'(ST_EMPTY_CELL) : fields.status;

   // --------------------------------------------------
   // array control word
   // --------------------------------------------------
   assign array_ctl.row_sel   = row_sel;
   assign array_ctl.col_sel   = col_sel;
   assign array_ctl.row_l     = p1.y;     // p1 is the lower corner
   assign array_ctl.col_l     = p1.x;
   assign array_ctl.row_u     = p2.y;     // p2 the upper
   assign array_ctl.col_u     = p2.x;
   assign array_ctl.cell_cmd  = cell_cmd;
   assign array_ctl.status_wr = status_wr;

   // --------------------------------------------------
   // result word
   // --------------------------------------------------
   // code on top, read status in the low nibble
   assign result_out = {RES_STATUS, 25'd0, status_rd};
   assign result_wr  = result_wr_en;

endmodule

//--- source/route_top.sv
module route_top
   import router_pkg::*;
#(
   parameter int NLAYERS = 4,
   parameter int NLBITS  = 2,
   parameter int NRBITS  = 4,
   parameter int NCBITS  = 4
)
(
   input  logic              clk,
   input  logic              fourlayer_cnt_reset,
   input  logic              cmd_empty,     // host command fifo
   input  logic [CMD_W-1:0]  cmd_in,
   output logic              cmd_rd,
   input  logic              result_full,   // result fifo
   output logic [CMD_W-1:0]  result_out,
   output logic              result_wr,
   output array_ctl_t        array_ctl,     // cell array
   input  logic [3:0]        status_rd,
   output logic [NLBITS-1:0] cur_layer,
   output logic              top_l
);

   cmd_fields_t fields;
   point_t      p1, p2;
   logic        layer_start, layer_last;
   logic        cmdreg_lden, sel_lden, advance;
   decode_sel_e row_sel, col_sel;
   cell_cmd_e   cell_cmd;
   logic        status_src, result_wr_en;

   cmd_fetch cmd_fetch_i (
      .clk, .fourlayer_cnt_reset, .cmd_in, .cmdreg_lden, .fields
   );

   endpoint_regs #(.NLBITS(NLBITS), .NRBITS(NRBITS), .NCBITS(NCBITS)) endpoint_regs_i (
      .clk, .fourlayer_cnt_reset, .sel_lden, .fields, .cur_layer,
      .p1, .p2, .layer_start, .layer_last
   );

   layer_counter #(.NLAYERS(NLAYERS), .NLBITS(NLBITS)) layer_counter_i (
      .clk, .fourlayer_cnt_reset, .advance, .cur_layer, .top_l
   );

   route_ctl_fsm #(.NLAYERS(NLAYERS), .NLBITS(NLBITS)) route_ctl_fsm_i (
      .clk, .fourlayer_cnt_reset, .cmd_empty, .result_full, .fields,
      .layer_start, .layer_last, .top_l, .cmd_rd, .cmdreg_lden, .sel_lden,
      .advance, .row_sel, .col_sel, .cell_cmd, .status_src,
      .result_wr (result_wr_en)
   );

   array_port array_port_i (
      .p1, .p2, .fields, .row_sel, .col_sel, .cell_cmd, .status_src,
      .result_wr_en, .status_rd, .array_ctl, .result_out, .result_wr
   );

endmodule

//--- tb/route_tb.sv
module route_tb
   import router_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NLAYERS = 4;
   localparam int NLBITS  = 2;
   localparam int NRBITS  = 4;
   localparam int NCBITS  = 4;

   logic              clk                 = 1'b0;
   logic              fourlayer_cnt_reset = 1'b1;
   logic              cmd_empty           = 1'b1;
   logic [CMD_W-1:0]  cmd_in              = '0;
   logic              result_full         = 1'b0;
   logic              cmd_rd, result_wr;
   logic [CMD_W-1:0]  result_out;
   array_ctl_t        array_ctl;
   logic [3:0]        status_rd;
   logic [NLBITS-1:0] cur_layer;
   logic              top_l;

   // cell array model and its shadow indexed [layer][row][col]
   logic [3:0] cells  [NLAYERS][1 << NRBITS][1 << NCBITS] = '{default: '0};
   logic [3:0] shadow [NLAYERS][1 << NRBITS][1 << NCBITS] = '{default: '0};

   logic [CMD_W-1:0] host_q[$];              // host command fifo
   logic [3:0]       exp_q[$];               // expected read statuses
   int               range_layers[$];        // layer of each range write
   int               range_cycles[$];
   logic [15:0]      lfsr = 16'd75;
   int cyc = 0, cmd_total = 0, reads_issued = 0, result_cnt = 0, write_cnt = 0;
   int clrx_len = 0, clrx_runs = 0, all_len = 0, all_runs = 0;
   int sel_x1, sel_x2, sel_y1, sel_y2, sel_z1, sel_z2;   // last selected box

   route_top #(.NLAYERS(NLAYERS), .NLBITS(NLBITS), .NRBITS(NRBITS), .NCBITS(NCBITS))
   route_top_i (
      .clk, .fourlayer_cnt_reset, .cmd_empty, .cmd_in, .cmd_rd, .result_full,
      .result_out, .result_wr, .array_ctl, .status_rd, .cur_layer, .top_l
   );

   initial
   begin
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;
   always @(posedge clk) fourlayer_cnt_reset <= (cyc < 7);   // 8 reset edges

   // --------------------------------------------------
   // error exits and random bits
   // --------------------------------------------------
   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic raise_error(input string msg);
      $display("ERROR at %0d ns: %s", $time, msg);
      abort_run();
   endtask

   // 16-bit fibonacci lfsr with taps 16 14 13 11 stepped once per bit
   function automatic int take_bits(input int n);
      int   v;
      logic fb;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = (v << 1) | int'(fb);
      end
      return v;
   endfunction

   // row or column hit for one decoder setting
   function automatic logic in_sel(input decode_sel_e sel, input logic [COORD_W-1:0] lo,
                                   input logic [COORD_W-1:0] hi, input int idx);
      case (sel)
         DEC_LOWER: return idx == int'(lo);
         DEC_UPPER: return idx == int'(hi);
         DEC_RANGE: return idx >= int'(lo) && idx <= int'(hi);
         DEC_ALL:   return 1'b1;
         default:   return 1'b0;
      endcase
   endfunction

   // --------------------------------------------------
   // host fifo, result back-pressure, cell array
   // --------------------------------------------------
   always @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
      begin
         cmd_in      <= '0;
         cmd_empty   <= 1'b1;
         result_full <= 1'b0;
      end
      else
      begin
         if (cmd_rd && host_q.size() != 0)
            cmd_in <= host_q.pop_front();    // word appears the cycle after the pop
         cmd_empty   <= (host_q.size() == 0);
         result_full <= (take_bits(1) == 1); // stall about half the cycles
      end
   end

   always @(posedge clk)
   begin
      if (fourlayer_cnt_reset)
         cells <= '{default: '0};
      else if (array_ctl.cell_cmd == CELL_WRITE)
         for (int r = 0; r < (1 << NRBITS); r++)
            for (int c = 0; c < (1 << NCBITS); c++)
               if (in_sel(array_ctl.row_sel, array_ctl.row_l, array_ctl.row_u, r) &&
                   in_sel(array_ctl.col_sel, array_ctl.col_l, array_ctl.col_u, c))
                  cells[cur_layer][r][c] <= array_ctl.status_wr;
   end

   // cell at the lower corner on the current layer
   assign status_rd = cells[cur_layer][array_ctl.row_l[NRBITS-1:0]][array_ctl.col_l[NCBITS-1:0]];

   // --------------------------------------------------
   // checks on every cycle
   // --------------------------------------------------
   a_rd_pulse: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      cmd_rd |=> !cmd_rd) else raise_error("cmd_rd held for more than one cycle");
   a_rd_empty: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      cmd_rd |-> !cmd_empty) else raise_error("cmd_rd while the command fifo is empty");
   a_full: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      result_wr |-> !result_full) else raise_error("result_wr while result_full is high");
   a_res_fmt: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      result_wr |-> result_out[31:29] == RES_STATUS && result_out[28:4] == '0)
      else raise_error("result word is not a status word");
   a_clr_val: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      (array_ctl.cell_cmd == CELL_WRITE && array_ctl.row_sel == DEC_ALL) |->
      (array_ctl.col_sel == DEC_ALL && array_ctl.status_wr == ST_EMPTY_CELL))
      else raise_error("full clear does not write the empty status");
   a_wr_sel: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      (array_ctl.cell_cmd == CELL_WRITE && array_ctl.row_sel != DEC_ALL) |->
      (array_ctl.row_sel == DEC_RANGE && array_ctl.col_sel == DEC_RANGE))
      else raise_error("box write without range decoders");
   a_top: assert property (@(posedge clk) disable iff (fourlayer_cnt_reset)
      top_l == (int'(cur_layer) != NLAYERS - 1))
      else raise_error("top_l does not mark the top layer");

   always @(posedge clk)
   begin
      logic [3:0] exp_val;
      if (!fourlayer_cnt_reset)
      begin
         if (array_ctl.cell_cmd == CELL_WRITE && array_ctl.row_sel == DEC_RANGE)
         begin
            range_layers.push_back(int'(cur_layer));
            range_cycles.push_back(cyc);
         end
         if (array_ctl.cell_cmd == CELL_WRITE)
            write_cnt++;
         // clearx pass length checked when the pass ends
         if (array_ctl.cell_cmd == CELL_CLEARX)
            clrx_len++;
         else if (clrx_len != 0)
         begin
            assert (clrx_len == NLAYERS)
               else raise_error($sformatf("clearx ran %0d cycles", clrx_len));
            clrx_runs++;
            clrx_len = 0;
         end
         if (array_ctl.cell_cmd == CELL_WRITE && array_ctl.row_sel == DEC_ALL)
         begin
            assert (all_len != 0 || cur_layer == '0)
               else raise_error("full clear does not start on layer 0");
            all_len++;
         end
         else if (all_len != 0)
         begin
            assert (all_len == NLAYERS)
               else raise_error($sformatf("full clear wrote %0d layers", all_len));
            all_runs++;
            all_len = 0;
         end
         if (result_wr)
         begin
            assert (exp_q.size() != 0) else raise_error("result word with no read pending");
            exp_val = exp_q.pop_front();
            assert (result_out[3:0] == exp_val)
               else raise_error($sformatf("read status %h, expected %h",
                                          result_out[3:0], exp_val));
            result_cnt++;
         end
      end
   end

   // --------------------------------------------------
   // command helpers
   // --------------------------------------------------
   task automatic push_cmd(input logic [CMD_W-1:0] word);
      @(negedge clk);
      host_q.push_back(word);
      cmd_total++;
   endtask

   // random ordered box with junk in the upper bits to test truncation
   task automatic select_box();
      int a, b, c, d, e, f;
      logic [9:0] hi;
      a = take_bits(4);
      b = take_bits(4);
      c = take_bits(4);
      d = take_bits(4);
      e = take_bits(2);
      f = take_bits(2);
      hi = 10'(take_bits(10));
      sel_x1 = (a < b) ? a : b;
      sel_x2 = (a < b) ? b : a;
      sel_y1 = (c < d) ? c : d;
      sel_y2 = (c < d) ? d : c;
      sel_z1 = (e < f) ? e : f;
      sel_z2 = (e < f) ? f : e;
      push_cmd({OP_SELECT, hi[0], 4'(sel_x1), hi[1], 4'(sel_y1), hi[4:2], 2'(sel_z1),
                hi[5], 4'(sel_x2), hi[6], 4'(sel_y2), hi[9:7], 2'(sel_z2)});
   endtask

   task automatic write_box(input int st);
      range_layers.delete();
      range_cycles.delete();
      for (int l = sel_z1; l <= sel_z2; l++)
         for (int r = sel_y1; r <= sel_y2; r++)
            for (int c = sel_x1; c <= sel_x2; c++)
               shadow[l][r][c] = 4'(st);
      push_cmd({OP_EXTENDED, FCN_WRITE, 22'd0, 4'(st)});
   endtask

   task automatic read_p1();
      exp_q.push_back(shadow[sel_z1][sel_y1][sel_x1]);
      reads_issued++;
      push_cmd({OP_EXTENDED, FCN_READ, 26'd0});
   endtask

   // the read result also marks the end of every earlier command
   task automatic wait_results();
      int waited;
      waited = 0;
      while (result_cnt != reads_issued)
      begin
         @(negedge clk);
         waited++;
         if (waited > 1000)
         begin
            $display("timeout: no result word after %0d cycles", waited);
            abort_run();
         end
      end
   endtask

   // every queued word popped, so all earlier commands have finished
   task automatic wait_fifo_drained();
      int waited;
      waited = 0;
      while (host_q.size() != 0)
      begin
         @(negedge clk);
         waited++;
         if (waited > 1000)
         begin
            $display("timeout: command fifo not drained after %0d cycles", waited);
            abort_run();
         end
      end
   endtask

   task automatic check_write_layers();
      assert (range_layers.size() == sel_z2 - sel_z1 + 1)
         else raise_error($sformatf("%0d layer writes, expected %0d",
                                    range_layers.size(), sel_z2 - sel_z1 + 1));
      foreach (range_layers[i])
         assert (range_layers[i] == sel_z1 + i && range_cycles[i] == range_cycles[0] + i)
            else raise_error($sformatf("write %0d on layer %0d", i, range_layers[i]));
   endtask

   task automatic compare_array();
      for (int l = 0; l < NLAYERS; l++)
         for (int r = 0; r < (1 << NRBITS); r++)
            for (int c = 0; c < (1 << NCBITS); c++)
               assert (cells[l][r][c] == shadow[l][r][c])
                  else raise_error($sformatf("cell %0d/%0d/%0d is %h, expected %h",
                                             l, r, c, cells[l][r][c], shadow[l][r][c]));
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial
   begin
      int w0, r0, x0;
      repeat (7) @(posedge clk);
      @(negedge clk);
      assert (!cmd_rd && !result_wr && array_ctl.row_sel == DEC_DISABLE &&
              array_ctl.col_sel == DEC_DISABLE && array_ctl.cell_cmd == CELL_READ &&
              cur_layer == '0)
         else raise_error("outputs not idle during reset");
      while (fourlayer_cnt_reset)
         @(negedge clk);

      select_box();
      read_p1();
      wait_results();
      assert (int'(array_ctl.row_l) == sel_y1 && int'(array_ctl.row_u) == sel_y2 &&
              int'(array_ctl.col_l) == sel_x1 && int'(array_ctl.col_u) == sel_x2)
         else raise_error("array corners differ from the selected box");

      for (int n = 0; n < 10; n++)
      begin
         select_box();
         write_box(take_bits(4));
         read_p1();
         wait_results();
         check_write_layers();
         compare_array();
         select_box();                 // random cell often outside the box
         read_p1();
         wait_results();
      end

      x0 = clrx_runs;
      push_cmd({OP_EXTENDED, FCN_CLEARX, 26'd0});
      read_p1();
      wait_results();
      assert (clrx_runs == x0 + 1) else raise_error("clearx pass missing");

      x0 = all_runs;
      shadow = '{default: '0};
      push_cmd({OP_EXTENDED, FCN_CLEAR_ARRAY, 26'd0});
      read_p1();
      wait_results();
      assert (all_runs == x0 + 1) else raise_error("full clear pass missing");
      compare_array();
      repeat (4)
      begin
         select_box();
         read_p1();
      end
      wait_results();

      // ignored commands back to back so the decode chains them
      w0 = write_cnt;
      r0 = result_cnt;
      x0 = clrx_runs;
      push_cmd({OP_NOP, 30'h2aaa_aaaa});
      push_cmd({OP_ROUTE, 30'h1555_5555});
      push_cmd({OP_EXTENDED, FCN_ROUTE_EXTEND, 26'd5});
      push_cmd({OP_EXTENDED, 4'hb, 26'd0});
      read_p1();
      wait_fifo_drained();             // read taken, the ignored ones are done
      assert (write_cnt == w0 && result_cnt == r0 && clrx_runs == x0)
         else raise_error("ignored command caused array or result activity");
      wait_results();

      $display("Simulation passed");
      $finish;
   end

   // watchdog allows 200 cycles for each queued command
   initial
   begin
      forever
      begin
         @(posedge clk);
         if (cyc > 200 * (cmd_total + 1))
         begin
            $display("watchdog: %0d cycles used for %0d commands", cyc, cmd_total);
            abort_run();
         end
      end
   end

endmodule

//--- list.f
source/router_pkg.sv
source/cmd_fetch.sv
source/endpoint_regs.sv
source/layer_counter.sv
source/route_ctl_fsm.sv
source/array_port.sv
source/route_top.sv
tb/route_tb.sv

//--- Makefile
TOP = route_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f list.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf $(OBJ) sim.log
